//--- Makefile
# Verilator build and run of the punch subsystem testbench

TOP ?= punchSystem_tb
FLIST ?= punchSystem.f
LOG ?= sim.log
OBJDIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "variables: TOP FLIST LOG OBJDIR VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- logic/combat_consts.svh
`ifndef COMBAT_CONSTS_SVH
`define COMBAT_CONSTS_SVH

// punch phases, in frames
`define PUNCH_WINDUP 2
`define PUNCH_ACTIVE 4
`define PUNCH_RECOVER 3

// horizontal distance must stay below this for contact
`define PUNCH_REACH 135

// fist height below the fighter's y position
`define FIST_STAND_P1 30
`define FIST_JUMP_P1 40
`define FIST_STAND_P2 60
`define FIST_JUMP_P2 105

`define KEY_PUNCH_P1 8'h06
`define KEY_CROUCH_P1 8'h16
`define KEY_PUNCH_P2 8'h11
`define KEY_CROUCH_P2 8'h0e

// knockback length in frames and speeds in pixels per frame
`define KNOCK_FRAMES 8
`define KNOCK_HIT 6
`define KNOCK_BLOCK 2

`define ARENA_LEFT 16
`define ARENA_RIGHT 623

`endif

//--- logic/combat_pkg.sv
`default_nettype none

package combatPkg;

	// what a defender suffers in a frame
	typedef enum logic [1:0] {
		none,
		hit,
		block
	} outcome_t;

	// knockback timer of one defender
	typedef enum logic {
		still,
		pushed
	} knockState_t;

endpackage

`default_nettype wire

//--- logic/fighter_pkg.sv
`default_nettype none

package fighterPkg;

	// screen position in pixels, y grows downward
	typedef logic signed [11:0] coord_t;

	// horizontal motion in pixels per frame
	typedef logic signed [7:0] velocity_t;

	// one slot of a usb keyboard report
	typedef logic [7:0] keycode_t;

	// punch sequence of one fighter
	typedef enum logic [1:0] {
		idle,
		windup,
		active,
		recover
	} punchState_t;

endpackage

`default_nettype wire

//--- logic/hitResolver.sv
`timescale 1ns/10ps
`default_nettype none

`include "combat_consts.svh"

module hitResolver (
	input wire logic frame_clk,
	input wire logic rst,
	input wire logic punchingP1,
	input wire logic punchingP2,
	input wire logic crouchP1,
	input wire logic crouchP2,
	input wire fighterPkg::coord_t fistYP1,
	input wire fighterPkg::coord_t fistYP2,
	input wire fighterPkg::coord_t xPosP1,
	input wire fighterPkg::coord_t xPosP2,
	input wire fighterPkg::coord_t yPosP1,
	input wire fighterPkg::coord_t yPosP2,
	output combatPkg::outcome_t outcomeP1,
	output combatPkg::outcome_t outcomeP2,
	output logic landedP1,
	output logic landedP2
);
	import combatPkg::*;

	logic signed [12:0] xDiff;
	logic [12:0] xDist;
	logic inReach;
	logic contactP1;
	logic contactP2;

	// one extra bit so the difference cannot wrap
	assign xDiff = 13'(xPosP1) - 13'(xPosP2);
	assign xDist = xDiff[12] ? 13'($unsigned(-xDiff)) : 13'($unsigned(xDiff));
	assign inReach = (xDist < 13'(`PUNCH_REACH));

	////////////////////////////////////////////////////////////////////////////
	// contact in both directions
	// landed masks the frame the punch machine needs to leave active
	assign contactP1 = punchingP1 && !landedP1 && inReach && (fistYP1 > yPosP2);
	assign contactP2 = punchingP2 && !landedP2 && inReach && (fistYP2 > yPosP1);

	always_ff @(posedge frame_clk)
	begin
		if (rst)
		begin
			outcomeP1 <= none;
			outcomeP2 <= none;
			landedP1 <= 1'b0;
			landedP2 <= 1'b0;
		end
		else
		begin
			landedP1 <= contactP1;
			landedP2 <= contactP2;

			// outcomes are named after the defender
			if (!contactP2)
				outcomeP1 <= none;
			else if (crouchP1)
				outcomeP1 <= block;
			else
				outcomeP1 <= hit;

			if (!contactP1)
				outcomeP2 <= none;
			else if (crouchP2)
				outcomeP2 <= block;
			else
				outcomeP2 <= hit;
		end
	end

endmodule

`default_nettype wire

//--- logic/knockbackControl.sv
`timescale 1ns/10ps
`default_nettype none

`include "combat_consts.svh"

module knockbackControl (
	input wire logic frame_clk,
	input wire logic rst,
	input wire combatPkg::outcome_t outcome,
	input wire fighterPkg::coord_t xPos,
	input wire fighterPkg::coord_t opponentX,
	output fighterPkg::velocity_t knockback
);
	import fighterPkg::*;
	import combatPkg::*;

	knockState_t state;
	logic [3:0] frameCnt;
	velocity_t speed;
	logic pushLeft;
	logic atWall;

	////////////////////////////////////////////////////////////////////////////
	// push timer, restarted by every new outcome
	always_ff @(posedge frame_clk)
	begin
		if (rst)
		begin
			state <= still;
			frameCnt <= '0;
		end
		else if (outcome != none)
		begin
			state <= pushed;
			frameCnt <= '0;
		end
		else if (state == pushed)
		begin
			frameCnt <= frameCnt + 4'd1;
			if (frameCnt == 4'(`KNOCK_FRAMES - 1))
				state <= still;
		end
	end

	// speed and direction are taken when the outcome arrives
	always_ff @(posedge frame_clk)
	begin
		if (outcome != none)
		begin
			speed <= (outcome == hit) ? velocity_t'(`KNOCK_HIT) : velocity_t'(`KNOCK_BLOCK);
			pushLeft <= (xPos <= opponentX);
		end
	end

	// wall check uses the live position
	assign atWall = pushLeft ? (xPos <= coord_t'(`ARENA_LEFT)) :
		(xPos >= coord_t'(`ARENA_RIGHT));

	always_comb
	begin
		if ((state == still) || atWall)
			knockback = '0;
		else if (pushLeft)
			knockback = -speed;
		else
			knockback = speed;
	end

endmodule

`default_nettype wire

//--- logic/punchControl.sv
`timescale 1ns/10ps
`default_nettype none

`include "combat_consts.svh"

module punchControl #(
	parameter fighterPkg::keycode_t punchKey = `KEY_PUNCH_P1,
	parameter fighterPkg::keycode_t crouchKey = `KEY_CROUCH_P1,
	parameter fighterPkg::coord_t fistStand = `FIST_STAND_P1,
	parameter fighterPkg::coord_t fistJump = `FIST_JUMP_P1
) (
	input wire logic frame_clk,
	input wire logic rst,
	input wire fighterPkg::keycode_t keycode0,
	input wire fighterPkg::keycode_t keycode1,
	input wire fighterPkg::keycode_t keycode2,
	input wire fighterPkg::keycode_t keycode3,
	input wire logic crouch,
	input wire logic jump,
	input wire fighterPkg::coord_t yPos,
	input wire logic landed,
	output logic punching,
	output fighterPkg::coord_t fistY
);
	import fighterPkg::*;

	punchState_t state;
	logic [2:0] frameCnt;
	logic punchKeyDown;
	logic crouchKeyDown;
	logic request;

	////////////////////////////////////////////////////////////////////////////
	// key decode
	assign punchKeyDown = (keycode0 == punchKey) || (keycode1 == punchKey) ||
		(keycode2 == punchKey) || (keycode3 == punchKey);
	assign crouchKeyDown = (keycode0 == crouchKey) || (keycode1 == crouchKey) ||
		(keycode2 == crouchKey) || (keycode3 == crouchKey);

	// no punching out of a crouch
	assign request = punchKeyDown && !crouchKeyDown && !crouch;

	////////////////////////////////////////////////////////////////////////////
	// windup, active, recover
	always_ff @(posedge frame_clk)
	begin
		if (rst)
		begin
			state <= idle;
			frameCnt <= '0;
		end
		else
		begin
			frameCnt <= frameCnt + 3'd1;
			case (state)
				idle:
				begin
					frameCnt <= '0;
					if (request)
						state <= windup;
				end
				windup:
				begin
					if (frameCnt == 3'(`PUNCH_WINDUP - 1))
					begin
						state <= active;
						frameCnt <= '0;
					end
				end
				active:
				begin
					// a landed fist is pulled back at once
					if (landed || (frameCnt == 3'(`PUNCH_ACTIVE - 1)))
					begin
						state <= recover;
						frameCnt <= '0;
					end
				end
				default:
				begin
					if (frameCnt == 3'(`PUNCH_RECOVER - 1))
					begin
						state <= idle;
						frameCnt <= '0;
					end
				end
			endcase
		end
	end

	assign punching = (state == active);

	// fist height follows the body one frame late
	always_ff @(posedge frame_clk)
	begin
		fistY <= yPos + (jump ? fistJump : fistStand);
	end

endmodule

`default_nettype wire

//--- logic/punchSystem.sv
`timescale 1ns/10ps
`default_nettype none

`include "combat_consts.svh"

module punchSystem (
	input wire logic frame_clk,
	input wire logic rst,
	input wire fighterPkg::keycode_t keycode0,
	input wire fighterPkg::keycode_t keycode1,
	input wire fighterPkg::keycode_t keycode2,
	input wire fighterPkg::keycode_t keycode3,
	input wire logic crouchP1,
	input wire logic crouchP2,
	input wire logic jumpP1,
	input wire logic jumpP2,
	input wire fighterPkg::coord_t xPosP1,
	input wire fighterPkg::coord_t xPosP2,
	input wire fighterPkg::coord_t yPosP1,
	input wire fighterPkg::coord_t yPosP2,
	output logic punchingP1,
	output logic punchingP2,
	output combatPkg::outcome_t outcomeP1,
	output combatPkg::outcome_t outcomeP2,
	output fighterPkg::velocity_t knockbackP1,
	output fighterPkg::velocity_t knockbackP2
);
	import fighterPkg::*;

	coord_t fistYP1;
	coord_t fistYP2;
	logic landedP1;
	logic landedP2;

	////////////////////////////////////////////////////////////////////////////
	// attackers
	punchControl #(
		.punchKey(`KEY_PUNCH_P1),
		.crouchKey(`KEY_CROUCH_P1),
		.fistStand(`FIST_STAND_P1),
		.fistJump(`FIST_JUMP_P1)
	) punchP1 (
		.frame_clk(frame_clk), .rst(rst),
		.keycode0(keycode0), .keycode1(keycode1), .keycode2(keycode2), .keycode3(keycode3),
		.crouch(crouchP1), .jump(jumpP1), .yPos(yPosP1),
		.landed(landedP1), .punching(punchingP1), .fistY(fistYP1)
	);

	punchControl #(
		.punchKey(`KEY_PUNCH_P2),
		.crouchKey(`KEY_CROUCH_P2),
		.fistStand(`FIST_STAND_P2),
		.fistJump(`FIST_JUMP_P2)
	) punchP2 (
		.frame_clk(frame_clk), .rst(rst),
		.keycode0(keycode0), .keycode1(keycode1), .keycode2(keycode2), .keycode3(keycode3),
		.crouch(crouchP2), .jump(jumpP2), .yPos(yPosP2),
		.landed(landedP2), .punching(punchingP2), .fistY(fistYP2)
	);

	hitResolver resolver (
		.frame_clk(frame_clk), .rst(rst),
		.punchingP1(punchingP1), .punchingP2(punchingP2),
		.crouchP1(crouchP1), .crouchP2(crouchP2),
		.fistYP1(fistYP1), .fistYP2(fistYP2),
		.xPosP1(xPosP1), .xPosP2(xPosP2), .yPosP1(yPosP1), .yPosP2(yPosP2),
		.outcomeP1(outcomeP1), .outcomeP2(outcomeP2),
		.landedP1(landedP1), .landedP2(landedP2)
	);

	////////////////////////////////////////////////////////////////////////////
	// defenders
	knockbackControl knockP1 (
		.frame_clk(frame_clk), .rst(rst), .outcome(outcomeP1),
		.xPos(xPosP1), .opponentX(xPosP2), .knockback(knockbackP1)
	);

	knockbackControl knockP2 (
		.frame_clk(frame_clk), .rst(rst), .outcome(outcomeP2),
		.xPos(xPosP2), .opponentX(xPosP1), .knockback(knockbackP2)
	);

endmodule

`default_nettype wire

//--- punchSystem.f
+incdir+logic
logic/fighter_pkg.sv
logic/combat_pkg.sv
logic/punchControl.sv
logic/hitResolver.sv
logic/knockbackControl.sv
logic/punchSystem.sv
test/punchSystem_tb.sv

//--- test/punchSystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "combat_consts.svh"

module punchSystem_tb;
	import fighterPkg::*;
	import combatPkg::*;

	logic frame_clk;
	logic rst;
	keycode_t keycode0;
	keycode_t keycode1;
	keycode_t keycode2;
	keycode_t keycode3;
	logic crouchP1;
	logic crouchP2;
	logic jumpP1;
	logic jumpP2;
	coord_t xPosP1;
	coord_t xPosP2;
	coord_t yPosP1;
	coord_t yPosP2;
	logic punchingP1;
	logic punchingP2;
	outcome_t outcomeP1;
	outcome_t outcomeP2;
	velocity_t knockbackP1;
	velocity_t knockbackP2;

	// reference state where index 0 is P1 and 1 is P2
	punchState_t pState [2];
	int pCnt [2];
	coord_t fistM [2];
	logic landM [2];
	outcome_t outM [2];
	logic kState [2];
	int kCnt [2];
	velocity_t kSpeed [2];
	logic kLeft [2];
	logic [31:0] lfsr = 32'hb96cc44b;

	punchSystem i_dut (
		.frame_clk(frame_clk), .rst(rst),
		.keycode0(keycode0), .keycode1(keycode1), .keycode2(keycode2), .keycode3(keycode3),
		.crouchP1(crouchP1), .crouchP2(crouchP2), .jumpP1(jumpP1), .jumpP2(jumpP2),
		.xPosP1(xPosP1), .xPosP2(xPosP2), .yPosP1(yPosP1), .yPosP2(yPosP2),
		.punchingP1(punchingP1), .punchingP2(punchingP2),
		.outcomeP1(outcomeP1), .outcomeP2(outcomeP2),
		.knockbackP1(knockbackP1), .knockbackP2(knockbackP2)
	);

	initial
	begin
		frame_clk = 1'b0;
		forever #50 frame_clk = ~frame_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	function automatic logic requestFor(input keycode_t pk, input keycode_t ck, input logic cr);
		logic pDown;
		logic cDown;
		pDown = (keycode0 == pk) || (keycode1 == pk) || (keycode2 == pk) || (keycode3 == pk);
		cDown = (keycode0 == ck) || (keycode1 == ck) || (keycode2 == ck) || (keycode3 == ck);
		return pDown && !cDown && !cr;
	endfunction

	function automatic void stepModel();
		coord_t xs [2];
		coord_t ys [2];
		logic cr [2];
		logic jp [2];
		logic req [2];
		logic contact [2];
		int dx;
		xs[0] = xPosP1;
		xs[1] = xPosP2;
		ys[0] = yPosP1;
		ys[1] = yPosP2;
		cr[0] = crouchP1;
		cr[1] = crouchP2;
		jp[0] = jumpP1;
		jp[1] = jumpP2;
		req[0] = requestFor(`KEY_PUNCH_P1, `KEY_CROUCH_P1, crouchP1);
		req[1] = requestFor(`KEY_PUNCH_P2, `KEY_CROUCH_P2, crouchP2);
		dx = int'(xs[0]) - int'(xs[1]);
		if (dx < 0)
			dx = -dx;
		for (int a = 0; a < 2; a++)
			contact[a] = (pState[a] == active) && !landM[a] && (dx < `PUNCH_REACH) &&
				(fistM[a] > ys[1 - a]);
		for (int d = 0; d < 2; d++)
		begin
			// knockback sees the outcome of the previous frame
			if (outM[d] != none)
			begin
				kState[d] = 1'b1;
				kCnt[d] = 0;
				kSpeed[d] = (outM[d] == hit) ? velocity_t'(`KNOCK_HIT) :
					velocity_t'(`KNOCK_BLOCK);
				kLeft[d] = (xs[d] <= xs[1 - d]);
			end
			else if (kState[d])
			begin
				if (kCnt[d] == `KNOCK_FRAMES - 1)
					kState[d] = 1'b0;
				kCnt[d]++;
			end
		end
		for (int a = 0; a < 2; a++)
		begin
			case (pState[a])
				idle:
				begin
					pCnt[a] = 0;
					if (req[a])
						pState[a] = windup;
				end
				windup:
				begin
					pCnt[a]++;
					if (pCnt[a] == `PUNCH_WINDUP)
					begin
						pState[a] = active;
						pCnt[a] = 0;
					end
				end
				active:
				begin
					pCnt[a]++;
					if (landM[a] || (pCnt[a] == `PUNCH_ACTIVE))
					begin
						pState[a] = recover;
						pCnt[a] = 0;
					end
				end
				default:
				begin
					pCnt[a]++;
					if (pCnt[a] == `PUNCH_RECOVER)
					begin
						pState[a] = idle;
						pCnt[a] = 0;
					end
				end
			endcase
		end
		fistM[0] = ys[0] + (jp[0] ? coord_t'(`FIST_JUMP_P1) : coord_t'(`FIST_STAND_P1));
		fistM[1] = ys[1] + (jp[1] ? coord_t'(`FIST_JUMP_P2) : coord_t'(`FIST_STAND_P2));
		for (int d = 0; d < 2; d++)
		begin
			landM[d] = contact[d];
			outM[d] = !contact[1 - d] ? none : (cr[d] ? block : hit);
		end
	endfunction

	function automatic velocity_t knockExpected(input int d);
		coord_t x;
		logic wall;
		x = (d == 0) ? xPosP1 : xPosP2;
		wall = kLeft[d] ? (x <= coord_t'(`ARENA_LEFT)) : (x >= coord_t'(`ARENA_RIGHT));
		if (!kState[d] || wall)
			return '0;
		return kLeft[d] ? -kSpeed[d] : kSpeed[d];
	endfunction

	always @(posedge frame_clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 2; i++)
			begin
				pState[i] = idle;
				pCnt[i] = 0;
				landM[i] = 1'b0;
				outM[i] = none;
				kState[i] = 1'b0;
				kCnt[i] = 0;
			end
			fistM[0] = yPosP1 + (jumpP1 ? coord_t'(`FIST_JUMP_P1) : coord_t'(`FIST_STAND_P1));
			fistM[1] = yPosP2 + (jumpP2 ? coord_t'(`FIST_JUMP_P2) : coord_t'(`FIST_STAND_P2));
		end
		else
			stepModel();
	end

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkOutcome(input string name, input outcome_t got, input outcome_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkVelocity(input string name, input velocity_t got, input velocity_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// every output against the model at mid frame
	always @(negedge frame_clk)
	begin
		if (!rst)
		begin
			checkBit("punchingP1", punchingP1, pState[0] == active);
			checkBit("punchingP2", punchingP2, pState[1] == active);
			checkOutcome("outcomeP1", outcomeP1, outM[0]);
			checkOutcome("outcomeP2", outcomeP2, outM[1]);
			checkVelocity("knockbackP1", knockbackP1, knockExpected(0));
			checkVelocity("knockbackP2", knockbackP2, knockExpected(1));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic keycode_t randomKey();
		case (randomBits(3))
			0: return `KEY_PUNCH_P1;
			1: return `KEY_PUNCH_P2;
			2: return `KEY_CROUCH_P1;
			3: return `KEY_CROUCH_P2;
			4: return 8'h04;
			default: return 8'h00;
		endcase
	endfunction

	task automatic nextFrame();
		@(posedge frame_clk);
		#5;
	endtask

	task automatic placePlayers(input int x1, input int x2, input logic cr2);
		xPosP1 = coord_t'(x1);
		xPosP2 = coord_t'(x2);
		yPosP1 = 12'sd300;
		yPosP2 = 12'sd300;
		crouchP2 = cr2;
	endtask

	// one punch followed by the defender's single outcome and its push
	task automatic punchAndCheck(input int attacker, input outcome_t expOut,
		input velocity_t expKnock);
		int waited;
		keycode0 = (attacker == 0) ? `KEY_PUNCH_P1 : `KEY_PUNCH_P2;
		nextFrame();
		keycode0 = 8'h00;
		waited = 0;
		@(negedge frame_clk);
		while (((attacker == 0) ? outcomeP2 : outcomeP1) == none)
		begin
			waited++;
			if (waited > 20)
			begin
				$display("timeout: no outcome after the punch of player %0d", attacker + 1);
				$display("TEST FAILED");
				$fatal(1);
			end
			@(negedge frame_clk);
		end
		checkOutcome((attacker == 0) ? "outcomeP2" : "outcomeP1",
			(attacker == 0) ? outcomeP2 : outcomeP1, expOut);
		for (int k = 1; k <= 10; k++)
		begin
			@(negedge frame_clk);
			checkOutcome((attacker == 0) ? "outcomeP2" : "outcomeP1",
				(attacker == 0) ? outcomeP2 : outcomeP1, none);
			checkVelocity((attacker == 0) ? "knockbackP2" : "knockbackP1",
				(attacker == 0) ? knockbackP2 : knockbackP1,
				(k <= `KNOCK_FRAMES) ? expKnock : velocity_t'(0));
			if (k == 1)
				checkBit((attacker == 0) ? "punchingP1" : "punchingP2",
					(attacker == 0) ? punchingP1 : punchingP2, 1'b0);
		end
		nextFrame();
	endtask

	initial
	begin
		rst = 1'b1;
		keycode0 = 8'h00;
		keycode1 = 8'h00;
		keycode2 = 8'h00;
		keycode3 = 8'h00;
		crouchP1 = 1'b0;
		jumpP1 = 1'b0;
		jumpP2 = 1'b0;
		placePlayers(100, 600, 1'b0);
		repeat (4) @(posedge frame_clk);
		#5;
		rst = 1'b0;

		@(negedge frame_clk);
		checkBit("punchingP1", punchingP1, 1'b0);
		checkBit("punchingP2", punchingP2, 1'b0);
		checkOutcome("outcomeP1", outcomeP1, none);
		checkOutcome("outcomeP2", outcomeP2, none);
		checkVelocity("knockbackP1", knockbackP1, '0);
		checkVelocity("knockbackP2", knockbackP2, '0);

		// a held key with the players far apart gives one punch until recovery ends
		nextFrame();
		keycode0 = `KEY_PUNCH_P1;
		for (int k = 0; k <= 10; k++)
		begin
			@(posedge frame_clk);
			@(negedge frame_clk);
			checkBit("punchingP1", punchingP1, (k >= 2) && (k <= 5));
		end
		nextFrame();
		keycode0 = 8'h00;
		repeat (11) nextFrame();

		// crouch key in another slot and then the crouch input
		keycode0 = `KEY_PUNCH_P1;
		keycode1 = `KEY_CROUCH_P1;
		repeat (6) nextFrame();
		keycode1 = 8'h00;
		crouchP1 = 1'b1;
		repeat (6) nextFrame();
		checkBit("punchingP1", punchingP1, 1'b0);
		keycode0 = 8'h00;
		crouchP1 = 1'b0;
		nextFrame();

		placePlayers(200, 300, 1'b0);
		punchAndCheck(0, hit, velocity_t'(`KNOCK_HIT));
		placePlayers(200, 300, 1'b1);
		punchAndCheck(0, block, velocity_t'(`KNOCK_BLOCK));
		placePlayers(560, `ARENA_RIGHT, 1'b0);
		punchAndCheck(0, hit, velocity_t'(0));
		placePlayers(`ARENA_LEFT, 100, 1'b0);
		punchAndCheck(1, hit, velocity_t'(0));

		///////////////////////////////////////////////////////////////////////
		// random frames
		for (int f = 0; f < 2000; f++)
		begin
			keycode0 = randomKey();
			keycode1 = randomKey();
			keycode2 = randomKey();
			keycode3 = randomKey();
			crouchP1 = (randomBits(2) == 32'd3);
			crouchP2 = (randomBits(2) == 32'd3);
			jumpP1 = 1'(randomBits(1));
			jumpP2 = 1'(randomBits(1));
			xPosP1 = coord_t'(randomBits(10));
			xPosP2 = coord_t'(randomBits(10));
			yPosP1 = coord_t'(randomBits(9));
			yPosP2 = coord_t'(randomBits(9));
			nextFrame();
		end
		@(negedge frame_clk);

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
